// ==== ball/ballObject.sv ====
`timescale 1ns/1ps

module ballObject (
	input	logic				clk,
	input	logic				rst,
	input	gamePkg::coordT		pixelX,
	input	gamePkg::coordT		pixelY,
	input	logic				startOfFrame,
	input	logic				pause,
	input	logic				hitTop,
	input	logic				hitBottom,
	input	logic				hitLeft,
	input	logic				hitRight,
	input	logic				hitPaddle,
	output	logic				drawBall,
	output	gamePkg::missT		misses
);

gamePkg::coordT	ballX;
gamePkg::coordT	ballY;
gamePkg::coordT	nextBallX;
gamePkg::coordT	nextBallY;

// velocity sign, set means moving toward 0
logic			velXNeg;
logic			velYNeg;
logic			nextVelXNeg;
logic			nextVelYNeg;

// no frame has ended yet right after reset
logic			running;

logic			doUpdate;

assign doUpdate = startOfFrame && running && !pause;

// bounce rules, later ones win
always_comb begin
	nextVelXNeg = velXNeg;
	nextVelYNeg = velYNeg;
	if (hitTop) begin
		nextVelYNeg = 1'b0;
	end
	if (hitPaddle) begin
		nextVelYNeg = 1'b1;
	end
	if (hitLeft) begin
		nextVelXNeg = 1'b0;
	end
	if (hitRight) begin
		nextVelXNeg = 1'b1;
	end
end

// one pixel step along the new velocity
always_comb begin
	if (nextVelXNeg) begin
		nextBallX = ballX - 8'd1;
	end else begin
		nextBallX = ballX + 8'd1;
	end
	if (nextVelYNeg) begin
		nextBallY = ballY - 8'd1;
	end else begin
		nextBallY = ballY + 8'd1;
	end
end

always_ff @(posedge clk) begin
	if (rst) begin
		running <= 1'b0;
		ballX <= gamePkg::BALL_START_X;
		ballY <= gamePkg::BALL_START_Y;
		velXNeg <= 1'b0;
		velYNeg <= 1'b0;
		misses <= '0;
	end else begin
		if (startOfFrame) begin
			running <= 1'b1;
		end
		if (doUpdate) begin
			if (hitBottom) begin
				// missed, restart from the top
				ballX <= gamePkg::BALL_START_X;
				ballY <= gamePkg::BALL_START_Y;
				velXNeg <= 1'b0;
				velYNeg <= 1'b0;
				misses <= misses + 4'd1;
			end else begin
				ballX <= nextBallX;
				ballY <= nextBallY;
				velXNeg <= nextVelXNeg;
				velYNeg <= nextVelYNeg;
			end
		end
	end
end

assign drawBall = (pixelX >= ballX) && (pixelX < ballX + gamePkg::BALL_SIZE) &&
	(pixelY >= ballY) && (pixelY < ballY + gamePkg::BALL_SIZE);

endmodule

// ==== common/gamePkg.sv ====
package gamePkg;

	// pixel coordinate on the scaled screen
	typedef logic [7:0] coordT;

	// RGB332
	typedef logic [7:0] colorT;

	// wraps after 15
	typedef logic [3:0] missT;

	// screen, no blanking
	localparam coordT SCREEN_W = 8'd40;
	localparam coordT SCREEN_H = 8'd30;

	// border band width on every side
	localparam coordT BORDER = 8'd1;

	// ball square
	localparam coordT BALL_SIZE = 8'd4;
	localparam coordT BALL_START_X = 8'd18;
	localparam coordT BALL_START_Y = 8'd10;

	// paddle rectangle, top row at PADDLE_Y
	localparam coordT PADDLE_W = 8'd12;
	localparam coordT PADDLE_H = 8'd2;
	localparam coordT PADDLE_Y = 8'd26;
	localparam coordT PADDLE_START_X = 8'd14;

	// legal paddle x, keeps it out of the side bands
	localparam coordT PADDLE_MIN_X = BORDER;
	localparam coordT PADDLE_MAX_X = SCREEN_W - BORDER - PADDLE_W;

	// layer colours, highest priority first
	localparam colorT COLOR_BALL = 8'hFC;
	localparam colorT COLOR_PADDLE = 8'h1F;
	localparam colorT COLOR_BORDER = 8'hFF;
	localparam colorT COLOR_BACK = 8'h00;

endpackage

// ==== design/collisionDetector.sv ====
`timescale 1ns/1ps

module collisionDetector (
	input	logic	clk,
	input	logic	rst,
	input	logic	startOfFrame,
	input	logic	drawBall,
	input	logic	drawPaddle,
	input	logic	drawTopBorder,
	input	logic	drawBottomBorder,
	input	logic	drawLeftBorder,
	input	logic	drawRightBorder,
	output	logic	hitTop,
	output	logic	hitBottom,
	output	logic	hitLeft,
	output	logic	hitRight,
	output	logic	hitPaddle
);

logic	ballOnTop;
logic	ballOnBottom;
logic	ballOnLeft;
logic	ballOnRight;
logic	ballOnPaddle;

// overlaps at the current pixel
assign ballOnTop = drawBall && drawTopBorder;
assign ballOnBottom = drawBall && drawBottomBorder;
assign ballOnLeft = drawBall && drawLeftBorder;
assign ballOnRight = drawBall && drawRightBorder;
assign ballOnPaddle = drawBall && drawPaddle;

always_ff @(posedge clk) begin
	if (rst) begin
		hitTop <= 1'b0;
		hitBottom <= 1'b0;
		hitLeft <= 1'b0;
		hitRight <= 1'b0;
		hitPaddle <= 1'b0;
	end else if (startOfFrame) begin
		// ball takes the flags this cycle, start a new frame
		hitTop <= 1'b0;
		hitBottom <= 1'b0;
		hitLeft <= 1'b0;
		hitRight <= 1'b0;
		hitPaddle <= 1'b0;
	end else begin
		hitTop <= hitTop || ballOnTop;
		hitBottom <= hitBottom || ballOnBottom;
		hitLeft <= hitLeft || ballOnLeft;
		hitRight <= hitRight || ballOnRight;
		hitPaddle <= hitPaddle || ballOnPaddle;
	end
end

endmodule

// ==== design/gameTop.sv ====
`timescale 1ns/1ps

module gameTop (
	input	logic				clk,
	input	logic				rst,
	input	logic				moveLeft,
	input	logic				moveRight,
	input	logic				pause,
	output	gamePkg::colorT		rgb,
	output	gamePkg::coordT		outX,
	output	gamePkg::coordT		outY,
	output	logic				frameStart,
	output	gamePkg::missT		misses
);

gamePkg::coordT	pixelX;
gamePkg::coordT	pixelY;
logic			startOfFrame;

logic			drawTopBorder;
logic			drawBottomBorder;
logic			drawLeftBorder;
logic			drawRightBorder;
logic			drawBall;
logic			drawPaddle;

logic			hitTop;
logic			hitBottom;
logic			hitLeft;
logic			hitRight;
logic			hitPaddle;

rasterScan rasterScanInst (
	.clk(clk),
	.rst(rst),
	.pixelX(pixelX),
	.pixelY(pixelY),
	.startOfFrame(startOfFrame),
	.drawTopBorder(drawTopBorder),
	.drawBottomBorder(drawBottomBorder),
	.drawLeftBorder(drawLeftBorder),
	.drawRightBorder(drawRightBorder)
);

ballObject ballObjectInst (
	.clk(clk),
	.rst(rst),
	.pixelX(pixelX),
	.pixelY(pixelY),
	.startOfFrame(startOfFrame),
	.pause(pause),
	.hitTop(hitTop),
	.hitBottom(hitBottom),
	.hitLeft(hitLeft),
	.hitRight(hitRight),
	.hitPaddle(hitPaddle),
	.drawBall(drawBall),
	.misses(misses)
);

paddleObject paddleObjectInst (
	.clk(clk),
	.rst(rst),
	.pixelX(pixelX),
	.pixelY(pixelY),
	.startOfFrame(startOfFrame),
	.pause(pause),
	.moveLeft(moveLeft),
	.moveRight(moveRight),
	.drawPaddle(drawPaddle)
);

// game logic sees both objects here
collisionDetector collisionDetectorInst (
	.clk(clk),
	.rst(rst),
	.startOfFrame(startOfFrame),
	.drawBall(drawBall),
	.drawPaddle(drawPaddle),
	.drawTopBorder(drawTopBorder),
	.drawBottomBorder(drawBottomBorder),
	.drawLeftBorder(drawLeftBorder),
	.drawRightBorder(drawRightBorder),
	.hitTop(hitTop),
	.hitBottom(hitBottom),
	.hitLeft(hitLeft),
	.hitRight(hitRight),
	.hitPaddle(hitPaddle)
);

objectsMux objectsMuxInst (
	.clk(clk),
	.rst(rst),
	.pixelX(pixelX),
	.pixelY(pixelY),
	.startOfFrame(startOfFrame),
	.drawBall(drawBall),
	.drawPaddle(drawPaddle),
	.drawTopBorder(drawTopBorder),
	.drawBottomBorder(drawBottomBorder),
	.drawLeftBorder(drawLeftBorder),
	.drawRightBorder(drawRightBorder),
	.rgb(rgb),
	.outX(outX),
	.outY(outY),
	.frameStart(frameStart)
);

endmodule

// ==== design/objectsMux.sv ====
`timescale 1ns/1ps

module objectsMux (
	input	logic				clk,
	input	logic				rst,
	input	gamePkg::coordT		pixelX,
	input	gamePkg::coordT		pixelY,
	input	logic				startOfFrame,
	input	logic				drawBall,
	input	logic				drawPaddle,
	input	logic				drawTopBorder,
	input	logic				drawBottomBorder,
	input	logic				drawLeftBorder,
	input	logic				drawRightBorder,
	output	gamePkg::colorT		rgb,
	output	gamePkg::coordT		outX,
	output	gamePkg::coordT		outY,
	output	logic				frameStart
);

logic				drawBorder;
gamePkg::colorT		pixelColor;

assign drawBorder = drawTopBorder || drawBottomBorder || drawLeftBorder || drawRightBorder;

// ball over paddle over border over background
always_comb begin
	if (drawBall) begin
		pixelColor = gamePkg::COLOR_BALL;
	end else if (drawPaddle) begin
		pixelColor = gamePkg::COLOR_PADDLE;
	end else if (drawBorder) begin
		pixelColor = gamePkg::COLOR_BORDER;
	end else begin
		pixelColor = gamePkg::COLOR_BACK;
	end
end

// coordinates and frame pulse follow the colour by one cycle
always_ff @(posedge clk) begin
	if (rst) begin
		rgb <= gamePkg::COLOR_BACK;
		outX <= '0;
		outY <= '0;
		frameStart <= 1'b0;
	end else begin
		rgb <= pixelColor;
		outX <= pixelX;
		outY <= pixelY;
		frameStart <= startOfFrame;
	end
end

endmodule

// ==== design/rasterScan.sv ====
`timescale 1ns/1ps

module rasterScan (
	input	logic				clk,
	input	logic				rst,
	output	gamePkg::coordT		pixelX,
	output	gamePkg::coordT		pixelY,
	output	logic				startOfFrame,
	output	logic				drawTopBorder,
	output	logic				drawBottomBorder,
	output	logic				drawLeftBorder,
	output	logic				drawRightBorder
);

gamePkg::coordT	nextX;
gamePkg::coordT	nextY;

// next pixel in scan order
always_comb begin
	if (pixelX == gamePkg::SCREEN_W - 8'd1) begin
		nextX = '0;
		if (pixelY == gamePkg::SCREEN_H - 8'd1) begin
			nextY = '0;
		end else begin
			nextY = pixelY + 8'd1;
		end
	end else begin
		nextX = pixelX + 8'd1;
		nextY = pixelY;
	end
end

always_ff @(posedge clk) begin
	if (rst) begin
		// parked on the last pixel so the scan opens with (0,0)
		pixelX <= gamePkg::SCREEN_W - 8'd1;
		pixelY <= gamePkg::SCREEN_H - 8'd1;
		startOfFrame <= 1'b0;
		drawTopBorder <= 1'b0;
		drawBottomBorder <= 1'b0;
		drawLeftBorder <= 1'b0;
		drawRightBorder <= 1'b0;
	end else begin
		pixelX <= nextX;
		pixelY <= nextY;
		startOfFrame <= (nextX == '0) && (nextY == '0);
		drawTopBorder <= nextY < gamePkg::BORDER;
		drawBottomBorder <= nextY >= gamePkg::SCREEN_H - gamePkg::BORDER;
		drawLeftBorder <= nextX < gamePkg::BORDER;
		drawRightBorder <= nextX >= gamePkg::SCREEN_W - gamePkg::BORDER;
	end
end

endmodule

// ==== paddle/paddleObject.sv ====
`timescale 1ns/1ps

module paddleObject (
	input	logic				clk,
	input	logic				rst,
	input	gamePkg::coordT		pixelX,
	input	gamePkg::coordT		pixelY,
	input	logic				startOfFrame,
	input	logic				pause,
	input	logic				moveLeft,
	input	logic				moveRight,
	output	logic				drawPaddle
);

gamePkg::coordT	paddleX;

// first frame after reset keeps the start image
logic			running;

logic			doUpdate;
logic			stepLeft;
logic			stepRight;

assign doUpdate = startOfFrame && running && !pause;

// a single key only, and never into a side band
assign stepLeft = moveLeft && !moveRight && (paddleX > gamePkg::PADDLE_MIN_X);
assign stepRight = moveRight && !moveLeft && (paddleX < gamePkg::PADDLE_MAX_X);

always_ff @(posedge clk) begin
	if (rst) begin
		running <= 1'b0;
		paddleX <= gamePkg::PADDLE_START_X;
	end else begin
		if (startOfFrame) begin
			running <= 1'b1;
		end
		if (doUpdate) begin
			if (stepLeft) begin
				paddleX <= paddleX - 8'd1;
			end else if (stepRight) begin
				paddleX <= paddleX + 8'd1;
			end
		end
	end
end

// fixed rows, only x moves
assign drawPaddle = (pixelX >= paddleX) && (pixelX < paddleX + gamePkg::PADDLE_W) &&
	(pixelY >= gamePkg::PADDLE_Y) && (pixelY < gamePkg::PADDLE_Y + gamePkg::PADDLE_H);

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# builds the game testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 \
	--top-module gameTb \
	-Mdir obj_dir \
	-f verilog.f

./obj_dir/VgameTb

// ==== verification/gameModel.svh ====
`ifndef GAME_MODEL_SVH
`define GAME_MODEL_SVH

// model state of the game
gamePkg::coordT	modelBallX;
gamePkg::coordT	modelBallY;
logic			modelVxNeg;
logic			modelVyNeg;
gamePkg::coordT	modelPaddleX;
gamePkg::missT	modelMisses;
logic			modelRunning;

// overlaps seen since the last frame start
logic	accTop;
logic	accBottom;
logic	accLeft;
logic	accRight;
logic	accPaddle;

int		paddleBounces;
int		missEvents;
int		topBounces;
int		leftBounces;
int		rightBounces;

function automatic logic onBall(input gamePkg::coordT x, input gamePkg::coordT y);
	return x >= modelBallX && x < modelBallX + gamePkg::BALL_SIZE &&
		y >= modelBallY && y < modelBallY + gamePkg::BALL_SIZE;
endfunction

function automatic logic onPaddle(input gamePkg::coordT x, input gamePkg::coordT y);
	return x >= modelPaddleX && x < modelPaddleX + gamePkg::PADDLE_W &&
		y >= gamePkg::PADDLE_Y && y < gamePkg::PADDLE_Y + gamePkg::PADDLE_H;
endfunction

function automatic logic onBorder(input gamePkg::coordT x, input gamePkg::coordT y);
	return x < 8'd1 || x >= 8'd39 || y < 8'd1 || y >= 8'd29;
endfunction

function automatic gamePkg::colorT expectedColor(input gamePkg::coordT x,
		input gamePkg::coordT y);
	if (onBall(x, y)) begin
		return 8'hFC;
	end else if (onPaddle(x, y)) begin
		return 8'h1F;
	end else if (onBorder(x, y)) begin
		return 8'hFF;
	end
	return 8'h00;
endfunction

function automatic void accumulateHits(input gamePkg::coordT x, input gamePkg::coordT y);
	if (onBall(x, y)) begin
		accTop = accTop || y == 8'd0;
		accBottom = accBottom || y == 8'd29;
		accLeft = accLeft || x == 8'd0;
		accRight = accRight || x == 8'd39;
		accPaddle = accPaddle || onPaddle(x, y);
	end
endfunction

// one frame step, first frame after reset only arms the model
function automatic void updateModel(input logic pauseIn, input logic left, input logic right);
	if (!modelRunning) begin
		modelRunning = 1'b1;
	end else if (!pauseIn) begin
		if (accBottom) begin
			modelBallX = 8'd18;
			modelBallY = 8'd10;
			modelVxNeg = 1'b0;
			modelVyNeg = 1'b0;
			modelMisses = modelMisses + 4'd1;
			missEvents++;
		end else begin
			if (accTop) begin
				modelVyNeg = 1'b0;
				topBounces++;
			end
			if (accPaddle) begin
				modelVyNeg = 1'b1;
				paddleBounces++;
			end
			if (accLeft) begin
				modelVxNeg = 1'b0;
				leftBounces++;
			end
			if (accRight) begin
				modelVxNeg = 1'b1;
				rightBounces++;
			end
			modelBallX = modelVxNeg ? modelBallX - 8'd1 : modelBallX + 8'd1;
			modelBallY = modelVyNeg ? modelBallY - 8'd1 : modelBallY + 8'd1;
		end
		if (left && !right && modelPaddleX > 8'd1) begin
			modelPaddleX = modelPaddleX - 8'd1;
		end else if (right && !left && modelPaddleX < 8'd27) begin
			modelPaddleX = modelPaddleX + 8'd1;
		end
	end
	accTop = 1'b0;
	accBottom = 1'b0;
	accLeft = 1'b0;
	accRight = 1'b0;
	accPaddle = 1'b0;
endfunction

`endif

// ==== verification/gameTb.sv ====
`timescale 1ns/1ps

module gameTb;

logic			clk;
logic			rst;
logic			moveLeft;
logic			moveRight;
logic			pause;
gamePkg::colorT	rgb;
gamePkg::coordT	outX;
gamePkg::coordT	outY;
logic			frameStart;
gamePkg::missT	misses;

logic [31:0]	rngState;
gamePkg::coordT	expX;
gamePkg::coordT	expY;

localparam int NUM_FRAMES = 230;
localparam int FRAME_TIMEOUT = 1300;

`include "gameModel.svh"

gameTop dut_i (
	.clk(clk),
	.rst(rst),
	.moveLeft(moveLeft),
	.moveRight(moveRight),
	.pause(pause),
	.rgb(rgb),
	.outX(outX),
	.outY(outY),
	.frameStart(frameStart),
	.misses(misses)
);

always #20 clk = ~clk;

function automatic logic [31:0] xorshift(input logic [31:0] s);
	logic [31:0] v;
	v = s;
	v = v ^ (v << 13);
	v = v ^ (v >> 17);
	v = v ^ (v << 5);
	return v;
endfunction

task automatic checkValue(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
	if (expected !== actual) begin
		$display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
		$display("TEST RESULT: FAIL");
		$fatal(1, "mismatch");
	end
endtask

// returns 1 ns after the edge that raised frameStart
task automatic waitFrameStart();
	int n;
	n = 0;
	do begin
		@(posedge clk);
		#1;
		n++;
		if (n > FRAME_TIMEOUT) begin
			$display("timeout: no frameStart within %0d cycles", FRAME_TIMEOUT);
			$display("TEST RESULT: FAIL");
			$fatal(1, "timeout");
		end
	end while (frameStart !== 1'b1);
endtask

task automatic compareCycle();
	logic isStart;
	isStart = (expX == 8'd0) && (expY == 8'd0);
	checkValue("outX", expX, outX);
	checkValue("outY", expY, outY);
	checkValue("frameStart", {7'b0, isStart}, {7'b0, frameStart});
	checkValue("rgb", expectedColor(expX, expY), rgb);
	// (0,0) still shows the old frame and is never counted as a hit
	if (isStart) begin
		updateModel(pause, moveLeft, moveRight);
	end else begin
		accumulateHits(expX, expY);
	end
	checkValue("misses", {4'b0, modelMisses}, {4'b0, misses});
endtask

// compare process
initial begin
	modelBallX = 8'd18;
	modelBallY = 8'd10;
	modelVxNeg = 1'b0;
	modelVyNeg = 1'b0;
	modelPaddleX = 8'd14;
	modelMisses = '0;
	modelRunning = 1'b0;
	accTop = 1'b0;
	accBottom = 1'b0;
	accLeft = 1'b0;
	accRight = 1'b0;
	accPaddle = 1'b0;
	paddleBounces = 0;
	missEvents = 0;
	topBounces = 0;
	leftBounces = 0;
	rightBounces = 0;
	expX = 8'd0;
	expY = 8'd0;
	waitFrameStart();
	forever begin
		compareCycle();
		@(posedge clk);
		#1;
		if (expX == 8'd39) begin
			expX = 8'd0;
			expY = (expY == 8'd29) ? 8'd0 : expY + 8'd1;
		end else begin
			expX = expX + 8'd1;
		end
	end
end

// stimulus process
initial begin
	int frame;
	int ballMid;
	int padMid;
	clk = 1'b0;
	rst = 1'b1;
	moveLeft = 1'b0;
	moveRight = 1'b0;
	pause = 1'b0;
	rngState = 32'h5d52909c;
	@(posedge clk);
	#1;
	checkValue("reset rgb", 8'h00, rgb);
	checkValue("reset outX", 8'd0, outX);
	checkValue("reset outY", 8'd0, outY);
	checkValue("reset frameStart", 8'd0, {7'b0, frameStart});
	checkValue("reset misses", 8'd0, {4'b0, misses});
	@(posedge clk);
	#2;
	rst = 1'b0;
	for (frame = 0; frame < NUM_FRAMES; frame++) begin
		waitFrameStart();
		#1;
		rngState = xorshift(rngState);
		pause = 1'b0;
		moveLeft = 1'b0;
		moveRight = 1'b0;
		if (frame < 20) begin
			moveLeft = 1'b1;
		end else if (frame < 25) begin
			moveLeft = 1'b1;
			moveRight = 1'b1;
		end else if (frame < 30) begin
			moveLeft = 1'b0;
		end else if (frame < 61) begin
			moveRight = 1'b1;
		end else if (frame < 141) begin
			// keep the paddle centred under the ball
			ballMid = int'(modelBallX) + 2;
			padMid = int'(modelPaddleX) + 6;
			moveRight = padMid < ballMid;
			moveLeft = padMid > ballMid;
		end else if (frame < 181) begin
			moveLeft = 1'b1;
		end else if (frame < 191) begin
			pause = 1'b1;
			moveLeft = rngState[0];
			moveRight = rngState[1];
		end else begin
			pause = rngState[7:4] == 4'd0;
			moveLeft = rngState[0];
			moveRight = rngState[1];
		end
	end
	if (paddleBounces > 0 && missEvents > 0 && topBounces > 0 && leftBounces > 0 &&
			rightBounces > 0) begin
		$display("TEST RESULT: PASS");
		$finish;
	end else begin
		$display("a paddle bounce, a wall bounce or a miss never happened");
		$display("TEST RESULT: FAIL");
		$fatal(1, "directed behaviours not reached");
	end
end

endmodule

// ==== verilog.f ====
+incdir+verification
common/gamePkg.sv
design/rasterScan.sv
ball/ballObject.sv
paddle/paddleObject.sv
design/collisionDetector.sv
design/objectsMux.sv
design/gameTop.sv
verification/gameTb.sv
